// ==== zynq_host.f ====
hdl/zynq_shell_pkg.sv
hdl/zynq_machine_pkg.sv
hdl/zynq_csr_regs.sv
hdl/tag_bitbang_fsm.sv
hdl/reset_delay_counter.sv
hdl/machine_config_rom.sv
hdl/dram_addr_hash.sv
hdl/zynq_host_top.sv
tb/tb_zynq_host_top.sv

// ==== Bender.yml ====
package:
  name: zynq_host

sources:
  - hdl/zynq_shell_pkg.sv
  - hdl/zynq_machine_pkg.sv
  - hdl/zynq_csr_regs.sv
  - hdl/tag_bitbang_fsm.sv
  - hdl/reset_delay_counter.sv
  - hdl/machine_config_rom.sv
  - hdl/dram_addr_hash.sv
  - hdl/zynq_host_top.sv
  - target: simulation
    files:
      - tb/tb_zynq_host_top.sv

// ==== tb/tb_zynq_host_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_zynq_host_top;

  import zynq_shell_pkg::*;
  import zynq_machine_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int STIM_DELAY    = 2;
  localparam int RESET_CYCLES  = 8;
  localparam int NUM_TAG_BITS  = 24;
  localparam int NUM_ROM_READS = 16;
  localparam int NUM_HASH      = 64;
  localparam int NUM_HOLD      = 24;
  localparam int BUSY_LIMIT    = 4 * TAG_HALF_CYCLES;
  localparam int TEST_CYCLES   = RESET_CYCLES + 4 * (RESET_DEPTH + 8)
                               + NUM_TAG_BITS * (2 * TAG_HALF_CYCLES + 8)
                               + NUM_ROM_READS * 4 + NUM_HASH + NUM_HOLD + 32;

  logic         aclk = 1'b0;
  logic         arst_n_i;
  logic         csr_wr_i;
  csr_addr_t    csr_addr_i;
  csr_data_t    csr_wdata_i;
  csr_rd_addr_t csr_rd_addr_i;
  csr_data_t    csr_rdata_o;
  dram_addr_t   cache_addr_i;
  cache_id_t    cache_id_i;
  logic         cache_addr_v_i;
  dram_addr_t   dram_addr_o;
  logic         dram_addr_v_o;
  logic         tag_clk_o;
  logic         tag_data_o;
  logic         core_reset_o;

  // reference model state
  logic       m_sys_resetn;
  logic       m_tag_bit;
  logic       m_tag_new;
  dram_addr_t m_dram_base;
  rom_addr_t  m_rom_addr;
  int         m_high_run;
  logic       m_core_reset;
  int         m_busy_cnt;
  logic       tag_q [$];
  logic       m_addr_v;
  dram_addr_t m_addr;
  csr_data_t  rom_exp [ROM_ELS];

  logic        tag_clk_prev = 1'b0;
  logic        sent_bit;
  int          error_count = 0;
  logic [31:0] lfsr_q = 32'd92;

  zynq_host_top dut_i
  (
    .aclk           (aclk),
    .arst_n_i       (arst_n_i),
    .csr_wr_i       (csr_wr_i),
    .csr_addr_i     (csr_addr_i),
    .csr_wdata_i    (csr_wdata_i),
    .csr_rd_addr_i  (csr_rd_addr_i),
    .csr_rdata_o    (csr_rdata_o),
    .cache_addr_i   (cache_addr_i),
    .cache_id_i     (cache_id_i),
    .cache_addr_v_i (cache_addr_v_i),
    .dram_addr_o    (dram_addr_o),
    .dram_addr_v_o  (dram_addr_v_o),
    .tag_clk_o      (tag_clk_o),
    .tag_data_o     (tag_data_o),
    .core_reset_o   (core_reset_o)
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r[i]   = lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  // id on top of the window and low address bits below it
  function automatic dram_addr_t hash_rule(input dram_addr_t addr, input cache_id_t id);
    dram_addr_t w;
    w = '0;
    w[DRAM_ADDR_WIDTH-LG_NUM_DMA-1:0]  = addr[DRAM_ADDR_WIDTH-LG_NUM_DMA-1:0];
    w[DRAM_ADDR_WIDTH-1 -: LG_NUM_DMA] = id;
    return w;
  endfunction

  task automatic stop_run();
    error_count++;
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic abort_with_reason(input string reason);
    $display("%s (at %0t ns)", reason, $time);
    stop_run();
  endtask

  task automatic check_data(input csr_data_t got, input csr_data_t exp, input string what);
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_addr(input dram_addr_t got, input dram_addr_t exp, input string what);
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s, expected %b, got %b", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic step();
    @(posedge aclk);
    #(STIM_DELAY);
    csr_wr_i = 1'b0;
  endtask

  task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
    csr_wr_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    step();
  endtask

  // expects the status word on the read port
  task automatic wait_tag_idle();
    int n;
    n = 0;
    while (csr_rdata_o[1])
    begin
      if (n == BUSY_LIMIT)
        abort_with_reason("bit-bang stayed busy past its limit");
      else
      begin
        step();
        n++;
      end
    end
  endtask

  task automatic wait_core_release();
    int n;
    n = 0;
    while (core_reset_o)
    begin
      if (n == 2 * RESET_DEPTH + 4)
        abort_with_reason("core reset was never released");
      else
      begin
        step();
        n++;
      end
    end
  endtask

  ////////////////////
  // model
  ////////////////////

  always @(posedge aclk)
  begin
    if (!arst_n_i)
    begin
      m_sys_resetn = 1'b0;
      m_tag_bit    = 1'b0;
      m_tag_new    = 1'b0;
      m_dram_base  = '0;
      m_rom_addr   = '0;
      m_high_run   = 0;
      m_core_reset = 1'b1;
      m_busy_cnt   = 0;
      m_addr_v     = 1'b0;
      tag_q.delete();
    end
    else
    begin
      // pipeline sees pre-edge core reset and base
      m_addr_v = cache_addr_v_i && !m_core_reset;
      m_addr   = hash_rule(cache_addr_i, cache_id_i) + m_dram_base;
      // requests that arrive while busy are dropped
      if (m_busy_cnt == 0 && m_tag_new)
      begin
        tag_q.push_back(m_tag_bit);
        m_busy_cnt = 2 * TAG_HALF_CYCLES;
      end
      else if (m_busy_cnt > 0)
        m_busy_cnt = m_busy_cnt - 1;
      // released after RESET_DEPTH+1 edges of sampled high
      if (m_sys_resetn)
        m_high_run = (m_high_run > RESET_DEPTH) ? m_high_run : m_high_run + 1;
      else
        m_high_run = 0;
      m_core_reset = (m_high_run <= RESET_DEPTH);
      m_tag_new    = csr_wr_i && (csr_addr_i == CSR_TAG_BIT);
      if (csr_wr_i)
      begin
        case (csr_addr_i)
          CSR_SYS_RESETN: m_sys_resetn = csr_wdata_i[0];
          CSR_TAG_BIT:    m_tag_bit    = csr_wdata_i[0];
          CSR_DRAM_BASE:  m_dram_base  = csr_wdata_i;
          CSR_ROM_ADDR:   m_rom_addr   = csr_wdata_i[$bits(rom_addr_t)-1:0];
          default:        ;
        endcase
      end
    end
  end

  // outputs are settled by the falling edge
  always @(negedge aclk)
  begin
    if (arst_n_i)
    begin
      check_bit(core_reset_o, m_core_reset, "core reset");
      check_bit(dram_addr_v_o, m_addr_v, "dram address valid");
      if (m_addr_v)
        check_addr(dram_addr_o, m_addr, "dram address");
      check_bit(tag_clk_o, (m_busy_cnt > 0) && (m_busy_cnt <= TAG_HALF_CYCLES), "tag clock");
      if (tag_clk_o && !tag_clk_prev)
      begin
        if (tag_q.size() == 0)
          abort_with_reason("tag clock rose with no tag bit pending");
        else
        begin
          sent_bit = tag_q.pop_front();
          check_bit(tag_data_o, sent_bit, "tag data at tag clock rise");
        end
      end
      tag_clk_prev = tag_clk_o;
      if (csr_rd_addr_i == CSR_RD_STATUS)
        check_data(csr_rdata_o, {{(CSR_DATA_WIDTH-2){1'b0}}, m_busy_cnt != 0, m_core_reset},
                   "status read back");
      else
        check_data(csr_rdata_o, rom_exp[m_rom_addr], "rom read back");
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    rom_addr_t  rom_sel;
    dram_addr_t base_val;
    dram_addr_t exp_addr;
    csr_addr_t  unused_idx [4];

    unused_idx     = '{3'd2, 3'd5, 3'd6, 3'd7};
    arst_n_i       = 1'b0;
    csr_wr_i       = 1'b0;
    csr_addr_i     = '0;
    csr_wdata_i    = '0;
    csr_rd_addr_i  = CSR_RD_STATUS;
    cache_addr_i   = '0;
    cache_id_i     = '0;
    cache_addr_v_i = 1'b0;

    // word 6 is the window width and word 7 sums words 0..6
    for (int i = 0; i < ROM_ELS - 2; i++)
      rom_exp[i] = ROM_CONTENTS[i];
    rom_exp[ROM_ELS-2] = 32'(DRAM_ADDR_WIDTH);
    rom_exp[ROM_ELS-1] = '0;
    for (int i = 0; i < ROM_ELS - 1; i++)
      rom_exp[ROM_ELS-1] = rom_exp[ROM_ELS-1] + rom_exp[i];

    repeat (RESET_CYCLES) @(posedge aclk);
    #(STIM_DELAY);
    arst_n_i = 1'b1;

    // state out of reset
    check_bit(core_reset_o, 1'b1, "core reset after reset");
    check_bit(tag_clk_o, 1'b0, "tag clock after reset");
    check_bit(dram_addr_v_o, 1'b0, "dram valid after reset");
    check_data(csr_rdata_o, 32'd1, "status after reset");
    step();

    // release then restart in mid-count and release again
    write_reg(CSR_SYS_RESETN, 32'd1);
    repeat (rand_bits(2) + 1) step();
    write_reg(CSR_SYS_RESETN, 32'd0);
    repeat (rand_bits(2)) step();
    write_reg(CSR_SYS_RESETN, 32'd1);
    wait_core_release();

    // tag bits with an occasional write while busy
    csr_rd_addr_i = CSR_RD_STATUS;
    step();
    for (int i = 0; i < NUM_TAG_BITS; i++)
    begin
      wait_tag_idle();
      write_reg(CSR_TAG_BIT, csr_data_t'(rand_bits(1)));
      step();
      if (rand_bits(2) == 0)
      begin
        step();
        write_reg(CSR_TAG_BIT, csr_data_t'(rand_bits(1)));
        step();
      end
    end
    wait_tag_idle();

    // writes to unused indices must not disturb the rom walk
    csr_rd_addr_i = CSR_RD_ROM;
    for (int i = 0; i < NUM_ROM_READS; i++)
    begin
      rom_sel = rom_addr_t'(rand_bits($bits(rom_addr_t)));
      write_reg(CSR_ROM_ADDR, csr_data_t'(rom_sel));
      check_data(csr_rdata_o, rom_exp[rom_sel], "rom word");
      write_reg(unused_idx[rand_bits(2)], csr_data_t'(rand_bits(32)));
      check_data(csr_rdata_o, rom_exp[rom_sel], "rom word after ignored write");
    end

    // one hashed address per cycle
    csr_rd_addr_i = CSR_RD_STATUS;
    wait_core_release();
    base_val = dram_addr_t'(rand_bits(32));
    write_reg(CSR_DRAM_BASE, base_val);
    for (int i = 0; i < NUM_HASH; i++)
    begin
      cache_addr_i   = dram_addr_t'(rand_bits(32));
      cache_id_i     = cache_id_t'(rand_bits(LG_NUM_DMA));
      cache_addr_v_i = 1'b1;
      exp_addr       = hash_rule(cache_addr_i, cache_id_i) + base_val;
      step();
      check_bit(dram_addr_v_o, 1'b1, "hashed address valid");
      check_addr(dram_addr_o, exp_addr, "hashed address");
    end
    cache_addr_v_i = 1'b0;
    step();

    // requests are swallowed while core reset is held
    write_reg(CSR_SYS_RESETN, 32'd0);
    step();
    for (int i = 0; i < NUM_HOLD; i++)
    begin
      cache_addr_i   = dram_addr_t'(rand_bits(32));
      cache_id_i     = cache_id_t'(rand_bits(LG_NUM_DMA));
      cache_addr_v_i = 1'b1;
      step();
      check_bit(dram_addr_v_o, 1'b0, "dram valid under core reset");
    end
    cache_addr_v_i = 1'b0;
    repeat (4) step();

    if (error_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    #(TEST_CYCLES * CLK_PERIOD * 4);
    $display("timeout: the test did not finish within %0d cycles", TEST_CYCLES * 4);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== hdl/zynq_host_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zynq_host_top
(
  input  logic                         aclk,
  input  logic                         arst_n_i,
  // host register port
  input  logic                         csr_wr_i,
  input  zynq_shell_pkg::csr_addr_t    csr_addr_i,
  input  zynq_shell_pkg::csr_data_t    csr_wdata_i,
  input  zynq_shell_pkg::csr_rd_addr_t csr_rd_addr_i,
  output zynq_shell_pkg::csr_data_t    csr_rdata_o,
  // cache miss addresses
  input  zynq_machine_pkg::dram_addr_t cache_addr_i,
  input  zynq_machine_pkg::cache_id_t  cache_id_i,
  input  logic                         cache_addr_v_i,
  output zynq_machine_pkg::dram_addr_t dram_addr_o,
  output logic                         dram_addr_v_o,
  // to the accelerator
  output logic                         tag_clk_o,
  output logic                         tag_data_o,
  output logic                         core_reset_o
);

  import zynq_shell_pkg::*;
  import zynq_machine_pkg::*;

  logic       sys_resetn;
  logic       tag_bit;
  logic       tag_bit_new;
  logic       tag_busy;
  dram_addr_t dram_base;
  rom_addr_t  rom_addr;
  csr_data_t  rom_data;

  zynq_csr_regs csr_regs_i
  (
    .aclk          (aclk),
    .arst_n_i      (arst_n_i),
    .csr_wr_i      (csr_wr_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rd_addr_i (csr_rd_addr_i),
    .core_reset_i  (core_reset_o),
    .tag_busy_i    (tag_busy),
    .rom_data_i    (rom_data),
    .csr_rdata_o   (csr_rdata_o),
    .sys_resetn_o  (sys_resetn),
    .tag_bit_o     (tag_bit),
    .tag_bit_new_o (tag_bit_new),
    .dram_base_o   (dram_base),
    .rom_addr_o    (rom_addr)
  );

  tag_bitbang_fsm bitbang_i
  (
    .aclk          (aclk),
    .arst_n_i      (arst_n_i),
    .tag_bit_i     (tag_bit),
    .tag_bit_new_i (tag_bit_new),
    .tag_clk_o     (tag_clk_o),
    .tag_data_o    (tag_data_o),
    .busy_o        (tag_busy)
  );

  reset_delay_counter reset_cnt_i
  (
    .aclk         (aclk),
    .arst_n_i     (arst_n_i),
    .sys_resetn_i (sys_resetn),
    .core_reset_o (core_reset_o)
  );

  machine_config_rom config_rom_i
  (
    .rom_addr_i (rom_addr),
    .rom_data_o (rom_data)
  );

  dram_addr_hash addr_hash_i
  (
    .aclk           (aclk),
    .arst_n_i       (arst_n_i),
    .core_reset_i   (core_reset_o),
    .cache_addr_i   (cache_addr_i),
    .cache_id_i     (cache_id_i),
    .cache_addr_v_i (cache_addr_v_i),
    .dram_base_i    (dram_base),
    .dram_addr_o    (dram_addr_o),
    .dram_addr_v_o  (dram_addr_v_o)
  );

endmodule

`default_nettype wire

// ==== hdl/dram_addr_hash.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_addr_hash
(
  input  logic                         aclk,
  input  logic                         arst_n_i,
  input  logic                         core_reset_i,
  input  zynq_machine_pkg::dram_addr_t cache_addr_i,
  input  zynq_machine_pkg::cache_id_t  cache_id_i,
  input  logic                         cache_addr_v_i,
  input  zynq_machine_pkg::dram_addr_t dram_base_i,
  output zynq_machine_pkg::dram_addr_t dram_addr_o,
  output logic                         dram_addr_v_o
);

  import zynq_machine_pkg::*;

  dram_addr_t hash;

  // cache id on top of the window, low cache address bits below it
  assign hash = dram_addr_t'({cache_id_i, cache_addr_i[DRAM_ADDR_WIDTH-LG_NUM_DMA-1:0]});

  always_ff @(posedge aclk)
  begin
    dram_addr_o <= hash + dram_base_i;
  end

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      dram_addr_v_o <= 1'b0;
    else
      dram_addr_v_o <= cache_addr_v_i && !core_reset_i;
  end

  no_addr_in_reset_a: assert property (
    @(posedge aclk) disable iff (!arst_n_i)
    core_reset_i |=> !dram_addr_v_o
  );

endmodule

`default_nettype wire

// ==== hdl/machine_config_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module machine_config_rom
(
  input  zynq_machine_pkg::rom_addr_t rom_addr_i,
  output zynq_shell_pkg::csr_data_t   rom_data_o
);

  import zynq_machine_pkg::*;

  ////////////////////
  // lookup
  ////////////////////

  // host walks this table at boot to size the machine
  always_comb
  begin
    case (rom_addr_i)
      3'd0:    rom_data_o = ROM_CONTENTS[0];
      3'd1:    rom_data_o = ROM_CONTENTS[1];
      3'd2:    rom_data_o = ROM_CONTENTS[2];
      3'd3:    rom_data_o = ROM_CONTENTS[3];
      3'd4:    rom_data_o = ROM_CONTENTS[4];
      3'd5:    rom_data_o = ROM_CONTENTS[5];
      3'd6:    rom_data_o = ROM_CONTENTS[6];
      3'd7:    rom_data_o = ROM_CONTENTS[7];
      default: rom_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/reset_delay_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_delay_counter
(
  input  logic aclk,
  input  logic arst_n_i,
  input  logic sys_resetn_i,
  output logic core_reset_o
);

  import zynq_machine_pkg::*;

  rst_cnt_t cnt_q;

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      core_reset_o <= 1'b1;
      cnt_q        <= '0;
    end
    else if (!sys_resetn_i)
    begin
      // any reassertion restarts the count
      core_reset_o <= 1'b1;
      cnt_q        <= '0;
    end
    else if (core_reset_o)
    begin
      if (cnt_q == rst_cnt_t'(RESET_DEPTH))
        core_reset_o <= 1'b0;
      else
        cnt_q <= cnt_q + 1'b1;
    end
  end

  // reset stays up through the whole count window
  core_reset_hold_a: assert property (
    @(posedge aclk) disable iff (!arst_n_i)
    (!sys_resetn_i ##1 sys_resetn_i [*1:RESET_DEPTH]) |=> core_reset_o
  );

endmodule

`default_nettype wire

// ==== hdl/tag_bitbang_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_bitbang_fsm
(
  input  logic aclk,
  input  logic arst_n_i,
  input  logic tag_bit_i,
  input  logic tag_bit_new_i,
  output logic tag_clk_o,
  output logic tag_data_o,
  output logic busy_o
);

  import zynq_shell_pkg::*;

  tag_state_e state_q;
  tag_phase_t phase_q;
  logic       phase_last;

  assign phase_last = (phase_q == tag_phase_t'(TAG_HALF_CYCLES-1));

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q    <= TAG_IDLE;
      phase_q    <= '0;
      tag_data_o <= 1'b0;
    end
    else
    begin
      case (state_q)
        TAG_IDLE:
        begin
          // data goes out one full phase ahead of the clock edge
          if (tag_bit_new_i)
          begin
            tag_data_o <= tag_bit_i;
            phase_q    <= '0;
            state_q    <= TAG_SETUP;
          end
        end
        TAG_SETUP:
        begin
          if (phase_last)
          begin
            phase_q <= '0;
            state_q <= TAG_HIGH;
          end
          else
            phase_q <= phase_q + 1'b1;
        end
        TAG_HIGH:
        begin
          if (phase_last)
          begin
            phase_q <= '0;
            state_q <= TAG_IDLE;
          end
          else
            phase_q <= phase_q + 1'b1;
        end
        default:
        begin
          phase_q <= '0;
          state_q <= TAG_IDLE;
        end
      endcase
    end
  end

  // outputs straight from the state register
  assign tag_clk_o = (state_q == TAG_HIGH);
  assign busy_o    = (state_q != TAG_IDLE);

  // tag master samples data anywhere in the high phase
  tag_data_stable_a: assert property (
    @(posedge aclk) disable iff (!arst_n_i)
    tag_clk_o |=> (!tag_clk_o || $stable(tag_data_o))
  );

endmodule

`default_nettype wire

// ==== hdl/zynq_csr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module zynq_csr_regs
(
  input  logic                         aclk,
  input  logic                         arst_n_i,
  input  logic                         csr_wr_i,
  input  zynq_shell_pkg::csr_addr_t    csr_addr_i,
  input  zynq_shell_pkg::csr_data_t    csr_wdata_i,
  input  zynq_shell_pkg::csr_rd_addr_t csr_rd_addr_i,
  input  logic                         core_reset_i,
  input  logic                         tag_busy_i,
  input  zynq_shell_pkg::csr_data_t    rom_data_i,
  output zynq_shell_pkg::csr_data_t    csr_rdata_o,
  output logic                         sys_resetn_o,
  output logic                         tag_bit_o,
  output logic                         tag_bit_new_o,
  output zynq_machine_pkg::dram_addr_t dram_base_o,
  output zynq_machine_pkg::rom_addr_t  rom_addr_o
);

  import zynq_shell_pkg::*;
  import zynq_machine_pkg::*;

  logic [NUM_WR_REGS-1:0] wr_en;
  csr_data_t              status;

  // one-hot decode, indices past the bank shift out to zero
  assign wr_en = csr_wr_i ? (NUM_WR_REGS'(1) << csr_addr_i) : '0;

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sys_resetn_o  <= 1'b0;
      tag_bit_o     <= 1'b0;
      tag_bit_new_o <= 1'b0;
      dram_base_o   <= '0;
      rom_addr_o    <= '0;
    end
    else
    begin
      if (wr_en[CSR_SYS_RESETN])
        sys_resetn_o <= csr_wdata_i[0];
      if (wr_en[CSR_TAG_BIT])
        tag_bit_o <= csr_wdata_i[0];
      if (wr_en[CSR_DRAM_BASE])
        dram_base_o <= csr_wdata_i;
      if (wr_en[CSR_ROM_ADDR])
        rom_addr_o <= rom_addr_t'(csr_wdata_i);
      // new-value strobe for the bit-bang
      tag_bit_new_o <= wr_en[CSR_TAG_BIT];
    end
  end

  ////////////////////
  // read back
  ////////////////////

  assign status = {{(CSR_DATA_WIDTH-2){1'b0}}, tag_busy_i, core_reset_i};

  always_comb
  begin
    case (csr_rd_addr_i)
      CSR_RD_STATUS: csr_rdata_o = status;
      CSR_RD_ROM:    csr_rdata_o = rom_data_i;
      default:       csr_rdata_o = '0;
    endcase
  end

  // host never issues back-to-back tag writes
  tag_new_single_a: assert property (
    @(posedge aclk) disable iff (!arst_n_i)
    tag_bit_new_o |=> !tag_bit_new_o
  );

endmodule

`default_nettype wire

// ==== hdl/zynq_machine_pkg.sv ====
`default_nettype none

package zynq_machine_pkg;

  ////////////////////
  // dram window
  ////////////////////

  // 128 MiB per shell
  localparam int DRAM_ADDR_WIDTH = 27;

  // cache id bits placed at the top of the window
  localparam int LG_NUM_DMA = 4;

  typedef logic [LG_NUM_DMA-1:0] cache_id_t;
  typedef logic [31:0]           dram_addr_t;

  ////////////////////
  // reset release
  ////////////////////

  localparam int RESET_DEPTH = 8;

  // must hold the value RESET_DEPTH itself
  typedef logic [$clog2(RESET_DEPTH+1)-1:0] rst_cnt_t;

  ////////////////////
  // config rom
  ////////////////////

  localparam int ROM_ELS = 8;

  typedef logic [$clog2(ROM_ELS)-1:0] rom_addr_t;

  // last word is the 32-bit sum of words 0..6
  localparam logic [31:0] ROM_CONTENTS [ROM_ELS] = '{
    32'h0002_0001,           // version
    32'd16,                  // tiles x
    32'd8,                   // tiles y
    32'd64,                  // cache sets
    32'd8,                   // cache ways
    32'd16,                  // line words
    32'(DRAM_ADDR_WIDTH),    // dram window bits
    32'h0002_008C
  };

endpackage

`default_nettype wire

// ==== hdl/zynq_shell_pkg.sv ====
`default_nettype none

package zynq_shell_pkg;

  ////////////////////
  // register file
  ////////////////////

  localparam int CSR_DATA_WIDTH = 32;
  localparam int CSR_ADDR_WIDTH = 3;

  typedef logic [CSR_DATA_WIDTH-1:0] csr_data_t;
  typedef logic [CSR_ADDR_WIDTH-1:0] csr_addr_t;

  // host to pl registers, index 2 left unused
  localparam csr_addr_t CSR_SYS_RESETN = 3'd0;
  localparam csr_addr_t CSR_TAG_BIT    = 3'd1;
  localparam csr_addr_t CSR_DRAM_BASE  = 3'd3;
  localparam csr_addr_t CSR_ROM_ADDR   = 3'd4;

  localparam int NUM_WR_REGS = 5;

  // pl to host registers
  typedef logic [0:0] csr_rd_addr_t;

  // status: bit 0 core reset, bit 1 bit-bang busy
  localparam csr_rd_addr_t CSR_RD_STATUS = 1'b0;
  localparam csr_rd_addr_t CSR_RD_ROM    = 1'b1;

  ////////////////////
  // tag bit-bang
  ////////////////////

  // aclk cycles per tag clock phase
  localparam int TAG_HALF_CYCLES = 4;

  typedef logic [$clog2(TAG_HALF_CYCLES)-1:0] tag_phase_t;

  typedef enum logic [1:0]
  {
    TAG_IDLE  = 2'd0,
    TAG_SETUP = 2'd1,
    TAG_HIGH  = 2'd2
  } tag_state_e;

endpackage

`default_nettype wire
